//--- design/csr_pkg.sv
package csr_pkg;

    // Commands issued by the pipeline
    typedef enum logic [2:0] {
        CSR_OP_NONE  = 3'd0,
        CSR_OP_RW    = 3'd1,
        CSR_OP_RS    = 3'd2,
        CSR_OP_RC    = 3'd3,
        CSR_OP_ECALL = 3'd4,
        CSR_OP_MRET  = 3'd5
    } csr_op_e;

    // Only machine and user modes exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Machine trap setup
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MEDELEG   = 12'h302;
    localparam logic [11:0] CSR_MIDELEG   = 12'h303;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_MIP       = 12'h344;

    // User counters, read only
    localparam logic [11:0] CSR_CYCLE     = 12'hc00;
    localparam logic [11:0] CSR_TIME      = 12'hc01;
    localparam logic [11:0] CSR_CYCLEH    = 12'hc80;
    localparam logic [11:0] CSR_TIMEH     = 12'hc81;

    // ID registers, all read as zero
    localparam logic [11:0] CSR_MVENDORID = 12'hf11;
    localparam logic [11:0] CSR_MARCHID   = 12'hf12;
    localparam logic [11:0] CSR_MIMPID    = 12'hf13;
    localparam logic [11:0] CSR_MHARTID   = 12'hf14;

    // Field positions
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;
    localparam int MIE_MTIE       = 7;
    localparam int MIP_MTIP       = 7;

    // Writable bits
    localparam logic [31:0] MSTATUS_WMASK = 32'h0000_1888;
    localparam logic [31:0] MIE_WMASK     = 32'h0000_0880;

    // MXL = 32 bit, extensions I and U
    localparam logic [31:0] MISA_VALUE    = 32'h4010_0100;

    // mcause codes
    localparam logic [31:0] CAUSE_ECALL_U = 32'd8;
    localparam logic [31:0] CAUSE_ECALL_M = 32'd11;
    localparam logic [31:0] CAUSE_MTIMER  = 32'h8000_0007;

    // Reset values
    localparam logic [31:0] MSTATUS_RESET  = 32'h0000_0000;
    localparam logic [63:0] MTIMECMP_RESET = 64'hffff_ffff_ffff_ffff;

    // Timer register offsets on APB
    localparam logic [11:0] MTIMER_ADDR_MTIME_LO = 12'h000;
    localparam logic [11:0] MTIMER_ADDR_MTIME_HI = 12'h004;
    localparam logic [11:0] MTIMER_ADDR_CMP_LO   = 12'h008;
    localparam logic [11:0] MTIMER_ADDR_CMP_HI   = 12'h00c;

    // Clocks per mtime tick
    localparam int MTIME_DIV   = 4;
    localparam int MTIME_DIV_W = $clog2(MTIME_DIV);

endpackage

//--- design/csr_req_if.sv
`timescale 1ns/10ps

// One accepted command, valid for a single cycle
interface csr_req_if import csr_pkg::*; ();

    logic        valid;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] operand;
    // PC of the issuing instruction, becomes mepc on ECALL
    logic [31:0] pc;

    // Input stage side
    modport stage (
        output valid,
        output op,
        output addr,
        output operand,
        output pc
    );

    // CSR file side, no ready since every cycle is accepted
    modport file (
        input valid,
        input op,
        input addr,
        input operand,
        input pc
    );

endinterface

//--- design/csr_rsp_if.sv
`timescale 1ns/10ps

// Results of the CSR file toward the output stage
interface csr_rsp_if ();

    // Read data of RW, RS or RC
    logic        rsp_valid;
    logic [31:0] rdata;
    // Trap entry or return target
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    modport file (
        output rsp_valid,
        output rdata,
        output redirect_valid,
        output redirect_pc
    );

    modport retire (
        input rsp_valid,
        input rdata,
        input redirect_valid,
        input redirect_pc
    );

endinterface

//--- design/csr_cmd_stage.sv
`timescale 1ns/10ps

module csr_cmd_stage import csr_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cmd_valid,
    input  csr_op_e     cmd_op,
    input  logic [11:0] cmd_addr,
    input  logic [31:0] cmd_operand,
    input  logic [31:0] cmd_pc,
    input  logic        cmd_flush,
    csr_req_if.stage    req
);

    logic accept;

    // Flushed commands and empty ops never reach the file
    assign accept = cmd_valid && !cmd_flush && (cmd_op != CSR_OP_NONE);

    // Valid bit follows accept every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
        end
    end

    // Payload held until the next accepted command
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op      <= cmd_op;
            req.addr    <= cmd_addr;
            req.operand <= cmd_operand;
            req.pc      <= cmd_pc;
        end
    end

endmodule

//--- design/mtimer_apb.sv
`timescale 1ns/10ps

module mtimer_apb import csr_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [63:0] mtime,
    output logic [63:0] cycle,
    output logic        timer_pending
);

    logic [MTIME_DIV_W-1:0] presc;
    logic [63:0]            mtimecmp;
    logic                   tick;
    logic                   access;
    logic                   addr_ok;
    logic                   wr_en;

    // Access phase of APB
    assign access = psel && penable;

    // Read mux and offset check
    always_comb begin
        addr_ok = 1'b1;
        case (paddr)
            MTIMER_ADDR_MTIME_LO: prdata = mtime[31:0];
            MTIMER_ADDR_MTIME_HI: prdata = mtime[63:32];
            MTIMER_ADDR_CMP_LO:   prdata = mtimecmp[31:0];
            MTIMER_ADDR_CMP_HI:   prdata = mtimecmp[63:32];
            default: begin
                prdata  = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    // Zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;
    // Bad offsets write nothing
    assign wr_en   = access && pwrite && addr_ok;

    // Prescaler wraps at MTIME_DIV
    assign tick = (presc == MTIME_DIV_W'(MTIME_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc    <= '0;
            cycle    <= '0;
            mtime    <= '0;
            mtimecmp <= MTIMECMP_RESET;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            cycle <= cycle + 64'd1;
            // Bus write wins over the tick
            if (wr_en && paddr == MTIMER_ADDR_MTIME_LO) begin
                mtime <= {mtime[63:32], pwdata};
            end else if (wr_en && paddr == MTIMER_ADDR_MTIME_HI) begin
                mtime <= {pwdata, mtime[31:0]};
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            if (wr_en && paddr == MTIMER_ADDR_CMP_LO) begin
                mtimecmp[31:0] <= pwdata;
            end
            if (wr_en && paddr == MTIMER_ADDR_CMP_HI) begin
                mtimecmp[63:32] <= pwdata;
            end
        end
    end

    // Level until mtimecmp is moved ahead
    assign timer_pending = (mtime >= mtimecmp);

endmodule

//--- design/csr_file.sv
`timescale 1ns/10ps

module csr_file import csr_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    csr_req_if.file     req,
    csr_rsp_if.file     rsp,
    input  logic [63:0] mtime,
    input  logic [63:0] cycle,
    input  logic        timer_pending,
    input  logic        irq_ready,
    input  logic [31:0] irq_pc,
    output logic        stall_req
);

    priv_e       mode;
    logic [31:0] mstatus_q;
    logic [31:0] mie_q;
    logic [31:0] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;
    logic [31:0] medeleg_q;
    logic [31:0] mip_val;
    logic [31:0] rd_val;
    logic [31:0] wr_val;
    logic [31:0] mstatus_wr;
    logic        is_rmw;
    logic        is_mret;
    logic        take_irq;
    logic        trap_enter;
    logic [31:0] trap_cause;
    logic [31:0] trap_epc;

    // Only MTIP is live
    always_comb begin
        mip_val           = '0;
        mip_val[MIP_MTIP] = timer_pending;
    end

    // Interrupt wanted, core must drain before it is taken
    assign stall_req = timer_pending && mie_q[MIE_MTIE] &&
                       (mode == PRIV_USER || mstatus_q[MSTATUS_MIE]);

    // Only while no command sits in the file
    assign take_irq = stall_req && irq_ready && !req.valid;

    assign is_rmw  = req.valid && (req.op == CSR_OP_RW || req.op == CSR_OP_RS ||
                                   req.op == CSR_OP_RC);
    assign is_mret = req.valid && (req.op == CSR_OP_MRET);
    assign trap_enter = take_irq || (req.valid && req.op == CSR_OP_ECALL);

    // Cause depends on the mode the ECALL came from
    assign trap_cause = take_irq ? CAUSE_MTIMER :
                        (mode == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    assign trap_epc   = take_irq ? irq_pc : req.pc;

    // Read mux, unimplemented addresses give zero
    always_comb begin
        case (req.addr)
            CSR_MSTATUS:   rd_val = mstatus_q;
            CSR_MISA:      rd_val = MISA_VALUE;
            CSR_MEDELEG:   rd_val = medeleg_q;
            CSR_MIDELEG:   rd_val = '0;
            CSR_MIE:       rd_val = mie_q;
            CSR_MTVEC:     rd_val = mtvec_q;
            CSR_MSCRATCH:  rd_val = mscratch_q;
            CSR_MEPC:      rd_val = mepc_q;
            CSR_MCAUSE:    rd_val = mcause_q;
            CSR_MTVAL:     rd_val = mtval_q;
            CSR_MIP:       rd_val = mip_val;
            CSR_CYCLE:     rd_val = cycle[31:0];
            CSR_TIME:      rd_val = mtime[31:0];
            CSR_CYCLEH:    rd_val = cycle[63:32];
            CSR_TIMEH:     rd_val = mtime[63:32];
            CSR_MVENDORID: rd_val = '0;
            CSR_MARCHID:   rd_val = '0;
            CSR_MIMPID:    rd_val = '0;
            CSR_MHARTID:   rd_val = '0;
            default:       rd_val = '0;
        endcase
    end

    // Write merge on the old value
    always_comb begin
        case (req.op)
            CSR_OP_RS: wr_val = rd_val | req.operand;
            CSR_OP_RC: wr_val = rd_val & ~req.operand;
            default:   wr_val = req.operand;
        endcase
    end

    // MPP only holds user or machine
    always_comb begin
        mstatus_wr = wr_val & MSTATUS_WMASK;
        if (mstatus_wr[MSTATUS_MPP_HI:MSTATUS_MPP_LO] != PRIV_MACHINE) begin
            mstatus_wr[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_USER;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode       <= PRIV_MACHINE;
            mstatus_q  <= MSTATUS_RESET;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            medeleg_q  <= '0;
        end else if (trap_enter) begin
            // ECALL and timer share the entry sequence
            mode     <= PRIV_MACHINE;
            mcause_q <= trap_cause;
            mepc_q   <= trap_epc;
            mtval_q  <= '0;
            mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
            mstatus_q[MSTATUS_MIE]  <= 1'b0;
            mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= mode;
        end else if (is_mret) begin
            // Back to the mode saved in MPP
            mode <= priv_e'(mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
            mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
            mstatus_q[MSTATUS_MPIE] <= 1'b1;
            mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= PRIV_USER;
        end else if (is_rmw) begin
            // Read-only addresses drop the write
            case (req.addr)
                CSR_MSTATUS:  mstatus_q  <= mstatus_wr;
                CSR_MEDELEG:  medeleg_q  <= wr_val;
                CSR_MIE:      mie_q      <= wr_val & MIE_WMASK;
                CSR_MTVEC:    mtvec_q    <= wr_val;
                CSR_MSCRATCH: mscratch_q <= wr_val;
                CSR_MEPC:     mepc_q     <= wr_val;
                CSR_MCAUSE:   mcause_q   <= wr_val;
                CSR_MTVAL:    mtval_q    <= wr_val;
                default:      ;
            endcase
        end
    end

    // Result flags, one cycle each
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp.rsp_valid      <= 1'b0;
            rsp.redirect_valid <= 1'b0;
        end else begin
            rsp.rsp_valid      <= is_rmw;
            rsp.redirect_valid <= trap_enter || is_mret;
        end
    end

    // Old value returned, direct mode target only
    always_ff @(posedge clk) begin
        if (is_rmw) begin
            rsp.rdata <= rd_val;
        end
        if (trap_enter) begin
            rsp.redirect_pc <= {mtvec_q[31:2], 2'b00};
        end else if (is_mret) begin
            rsp.redirect_pc <= mepc_q;
        end
    end

endmodule

//--- design/csr_retire_stage.sv
`timescale 1ns/10ps

module csr_retire_stage (
    input  logic        clk,
    input  logic        arst_n,
    csr_rsp_if.retire   rsp,
    output logic        rsp_valid,
    output logic [31:0] rsp_rdata,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    // Pulses drop unless set again
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            rsp_valid      <= rsp.rsp_valid;
            redirect_valid <= rsp.redirect_valid;
        end
    end

    // Data held between pulses
    always_ff @(posedge clk) begin
        if (rsp.rsp_valid) begin
            rsp_rdata <= rsp.rdata;
        end
        // Trap or MRET target
        if (rsp.redirect_valid) begin
            redirect_pc <= rsp.redirect_pc;
        end
    end

endmodule

//--- design/csr_unit_top.sv
`timescale 1ns/10ps

module csr_unit_top import csr_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // Pipeline commands
    input  logic        cmd_valid,
    input  csr_op_e     cmd_op,
    input  logic [11:0] cmd_addr,
    input  logic [31:0] cmd_operand,
    input  logic [31:0] cmd_pc,
    input  logic        cmd_flush,
    input  logic        irq_ready,
    input  logic [31:0] irq_pc,
    // Pipeline results
    output logic        rsp_valid,
    output logic [31:0] rsp_rdata,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        stall_req,
    // APB timer port
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [63:0] mtime;
    logic [63:0] cycle;
    logic        timer_pending;

    csr_req_if req_if ();
    csr_rsp_if rsp_if ();

    // Stage one registers the command
    csr_cmd_stage csr_cmd_stage_i (
        .clk, .arst_n, .cmd_valid, .cmd_op, .cmd_addr, .cmd_operand,
        .cmd_pc, .cmd_flush,
        .req (req_if.stage)
    );

    // Stage two executes it
    csr_file csr_file_i (
        .clk, .arst_n,
        .req (req_if.file),
        .rsp (rsp_if.file),
        .mtime, .cycle, .timer_pending, .irq_ready, .irq_pc, .stall_req
    );

    // Stage three drives the outputs
    csr_retire_stage csr_retire_stage_i (
        .clk, .arst_n,
        .rsp (rsp_if.retire),
        .rsp_valid, .rsp_rdata, .redirect_valid, .redirect_pc
    );

    mtimer_apb mtimer_apb_i (
        .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .mtime, .cycle, .timer_pending
    );

endmodule

//--- testbench/csr_unit_asserts.sv
`timescale 1ns/10ps

module csr_unit_asserts import csr_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    cmd_valid,
    input csr_op_e cmd_op,
    input logic    cmd_flush,
    input logic    rsp_valid,
    input logic    redirect_valid
);

    // Failed assertions so far
    int failures = 0;

    // Read result and redirect never share a cycle
    a_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(rsp_valid && redirect_valid))
        else begin
            $error("rsp_valid and redirect_valid high together");
            failures++;
        end

    // Redirect is a single-cycle pulse
    a_redirect_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !redirect_valid)
        else begin
            $error("redirect_valid held longer than one cycle");
            failures++;
        end

    // Read result three edges after an unflushed RW, RS or RC
    a_rsp_latency: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> $past(cmd_valid && !cmd_flush &&
                            (cmd_op == CSR_OP_RW || cmd_op == CSR_OP_RS ||
                             cmd_op == CSR_OP_RC), 3))
        else begin
            $error("rsp_valid without an accepted command three cycles earlier");
            failures++;
        end

    // Outputs quiet during reset
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!rsp_valid && !redirect_valid))
        else begin
            $error("valid output high during reset");
            failures++;
        end

endmodule

// Attached to the CSR unit top level
bind csr_unit_top csr_unit_asserts csr_unit_asserts_i (.*);

//--- testbench/csr_unit_tb.sv
`timescale 1ns/10ps

module csr_unit_tb import csr_pkg::*; ();

    // About 600 cycles of tests, limit with ample margin
    localparam int TIMEOUT_CYCLES = 2000;
    // Bound on any single handshake wait
    localparam int RSP_WAIT = 20;
    localparam logic [31:0] LFSR_SEED = 32'hc24f_4ab0;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk;
    logic        arst_n;
    logic        cmd_valid;
    csr_op_e     cmd_op;
    logic [11:0] cmd_addr;
    logic [31:0] cmd_operand;
    logic [31:0] cmd_pc;
    logic        cmd_flush;
    logic        irq_ready;
    logic [31:0] irq_pc;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        stall_req;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr;
    int          cycle_count;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    csr_unit_top csr_unit_top_i (.*);

    // 100 ns period
    always begin
        #50 clk = ~clk;
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Testbench failed");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, label, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    // Called at 1 ns after a rising edge, returns there too
    task automatic csr_cmd(input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] operand, input logic [31:0] pc,
                           output logic [31:0] result);
        int waited;
        waited      = 0;
        cmd_valid   = 1'b1;
        cmd_op      = op;
        cmd_addr    = addr;
        cmd_operand = operand;
        cmd_pc      = pc;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd_op    = CSR_OP_NONE;
        // Read data or redirect two edges later
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!rsp_valid && !redirect_valid && waited < RSP_WAIT);
        assert (rsp_valid || redirect_valid) else begin
            $display("%s: no response to the command at address %h", test_name, addr);
            errors++;
        end
        result = rsp_valid ? rsp_rdata : redirect_pc;
    endtask

    // RS with a zero operand reads without changing anything
    task automatic expect_csr(input logic [11:0] addr, input logic [31:0] expected,
                              input string label);
        logic [31:0] data;
        csr_cmd(CSR_OP_RS, addr, 32'd0, 32'd0, data);
        check_value(label, expected, data);
    endtask

    // One APB transfer, setup then access phase
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Sample mid-cycle once pready is seen
        @(negedge clk);
        while (!pready && waited < RSP_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (pready) else begin
            $display("%s: pready never rose at offset %h", test_name, addr);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic reset_values();
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        test_name     = "reset_values";
        // MXL 1 for RV32, I is bit 8, U is bit 20
        expect_csr(CSR_MISA, 32'h4010_0100, "misa");
        expect_csr(CSR_MVENDORID, 32'd0, "mvendorid");
        expect_csr(CSR_MHARTID, 32'd0, "mhartid");
        expect_csr(CSR_MTVEC, 32'd0, "mtvec");
        csr_cmd(CSR_OP_RS, CSR_MSTATUS, 32'd0, 32'd0, data);
        // MPP starts at user
        check_value("mstatus.MPP", 32'd0, {30'd0, data[12:11]});
        expect_csr(12'h7c0, 32'd0, "unimplemented");
        // Read-only ID register keeps zero
        csr_cmd(CSR_OP_RW, CSR_MVENDORID, 32'hdead_beef, 32'd0, data);
        check_value("mvendorid old", 32'd0, data);
        expect_csr(CSR_MVENDORID, 32'd0, "mvendorid after write");
        report_test(errors_before);
    endtask

    // Alternating mscratch and mie, one command per cycle
    task automatic rmw_burst();
        logic [31:0] exp_q[$];
        logic [31:0] scratch_m;
        logic [31:0] mie_m;
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] operand;
        csr_op_e     op;
        int          n;
        int          sent;
        int          got;
        int          waited;
        int          errors_before;
        errors_before = errors;
        test_name     = "rmw_burst";
        n         = 12;
        sent      = 0;
        got       = 0;
        waited    = 0;
        scratch_m = '0;
        mie_m     = '0;
        while (got < n && waited < n + RSP_WAIT) begin
            if (sent < n) begin
                case (next_bits(2))
                    32'd1:   op = CSR_OP_RS;
                    32'd2:   op = CSR_OP_RC;
                    default: op = CSR_OP_RW;
                endcase
                operand = next_bits(32);
                old_val = sent[0] ? mie_m : scratch_m;
                case (op)
                    CSR_OP_RS: new_val = old_val | operand;
                    CSR_OP_RC: new_val = old_val & ~operand;
                    default:   new_val = operand;
                endcase
                // mie keeps only MTIE (7) and MEIE (11)
                if (sent[0]) begin
                    mie_m = new_val & 32'h0000_0880;
                end else begin
                    scratch_m = new_val;
                end
                exp_q.push_back(old_val);
                cmd_valid   = 1'b1;
                cmd_op      = op;
                cmd_addr    = sent[0] ? CSR_MIE : CSR_MSCRATCH;
                cmd_operand = operand;
                cmd_pc      = 32'd0;
                sent++;
            end else begin
                cmd_valid = 1'b0;
                cmd_op    = CSR_OP_NONE;
            end
            @(posedge clk);
            #1;
            waited++;
            if (rsp_valid && exp_q.size() > 0) begin
                check_value("old value", exp_q.pop_front(), rsp_rdata);
                got++;
            end
        end
        cmd_valid = 1'b0;
        cmd_op    = CSR_OP_NONE;
        assert (got == n) else begin
            $display("%s: only %0d of %0d responses arrived", test_name, got, n);
            errors++;
        end
        report_test(errors_before);
    endtask

    task automatic trap_flow();
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        test_name     = "trap_flow";
        // Low bits set on purpose, target must drop them
        csr_cmd(CSR_OP_RW, CSR_MTVEC, 32'h0000_1003, 32'd0, data);
        csr_cmd(CSR_OP_RS, CSR_MSTATUS, 32'h0000_0008, 32'd0, data);
        csr_cmd(CSR_OP_ECALL, 12'd0, 32'd0, 32'h0000_0200, data);
        check_value("ecall redirect", 32'h0000_1000, data);
        expect_csr(CSR_MCAUSE, 32'd11, "mcause machine");
        expect_csr(CSR_MEPC, 32'h0000_0200, "mepc");
        // MPIE from MIE, MPP machine
        expect_csr(CSR_MSTATUS, 32'h0000_1880, "mstatus after ecall");
        // MPP to user so MRET leaves machine mode
        csr_cmd(CSR_OP_RC, CSR_MSTATUS, 32'h0000_1800, 32'd0, data);
        csr_cmd(CSR_OP_MRET, 12'd0, 32'd0, 32'd0, data);
        check_value("mret redirect", 32'h0000_0200, data);
        expect_csr(CSR_MSTATUS, 32'h0000_0088, "mstatus after mret");
        // Now in user mode
        csr_cmd(CSR_OP_ECALL, 12'd0, 32'd0, 32'h0000_0300, data);
        check_value("second redirect", 32'h0000_1000, data);
        expect_csr(CSR_MCAUSE, 32'd8, "mcause user");
        expect_csr(CSR_MEPC, 32'h0000_0300, "second mepc");
        report_test(errors_before);
    endtask

    task automatic flush_drop();
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        test_name     = "flush_drop";
        csr_cmd(CSR_OP_RW, CSR_MSCRATCH, 32'h1234_5678, 32'd0, data);
        cmd_valid   = 1'b1;
        cmd_flush   = 1'b1;
        cmd_op      = CSR_OP_RW;
        cmd_addr    = CSR_MSCRATCH;
        cmd_operand = 32'hffff_0000;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd_flush = 1'b0;
        cmd_op    = CSR_OP_NONE;
        // Past the fixed three-edge latency
        repeat (4) begin
            @(posedge clk);
            #1;
            assert (!rsp_valid) else begin
                $display("%s: flushed command produced a response", test_name);
                errors++;
            end
        end
        expect_csr(CSR_MSCRATCH, 32'h1234_5678, "mscratch");
        report_test(errors_before);
    endtask

    task automatic timer_irq();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] data;
        logic        err;
        int          waited;
        int          errors_before;
        errors_before = errors;
        test_name     = "timer_irq";
        apb_read(MTIMER_ADDR_MTIME_LO, t0, err);
        repeat (20) @(posedge clk);
        #1;
        apb_read(MTIMER_ADDR_MTIME_LO, t1, err);
        assert (t1 >= t0) else begin
            $display("%s: mtime went backwards from %h to %h", test_name, t0, t1);
            errors++;
        end
        apb_read(12'h010, data, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        // Low half first so the compare never drops below mtime early
        apb_write(MTIMER_ADDR_CMP_LO, t1 + 32'd6, err);
        apb_write(MTIMER_ADDR_CMP_HI, 32'd0, err);
        csr_cmd(CSR_OP_RS, CSR_MIE, 32'h0000_0080, 32'd0, data);
        csr_cmd(CSR_OP_RS, CSR_MSTATUS, 32'h0000_0008, 32'd0, data);
        waited = 0;
        while (!stall_req && waited < 200) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (stall_req) else begin
            $display("%s: stall_req never rose", test_name);
            errors++;
        end
        // Pipeline reports drained
        irq_pc    = 32'h0000_0480;
        irq_ready = 1'b1;
        waited    = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!redirect_valid && waited < RSP_WAIT);
        irq_ready = 1'b0;
        assert (redirect_valid) else begin
            $display("%s: no redirect after the interrupt", test_name);
            errors++;
        end
        check_value("irq redirect", 32'h0000_1000, redirect_pc);
        // Interrupt bit with code 7
        expect_csr(CSR_MCAUSE, 32'h8000_0007, "mcause");
        expect_csr(CSR_MEPC, 32'h0000_0480, "mepc");
        report_test(errors_before);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = CSR_OP_NONE;
        cmd_addr     = '0;
        cmd_operand  = '0;
        cmd_pc       = '0;
        cmd_flush    = 1'b0;
        irq_ready    = 1'b0;
        irq_pc       = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        lfsr         = LFSR_SEED;
        cycle_count  = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_values();
        rmw_burst();
        trap_flow();
        flush_drop();
        timer_irq();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors,
                 csr_unit_top_i.csr_unit_asserts_i.failures);
        if (errors == 0 && csr_unit_top_i.csr_unit_asserts_i.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- flist.f
design/csr_pkg.sv
design/csr_req_if.sv
design/csr_rsp_if.sv
design/csr_cmd_stage.sv
design/mtimer_apb.sv
design/csr_file.sv
design/csr_retire_stage.sv
design/csr_unit_top.sv
testbench/csr_unit_asserts.sv
testbench/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  # Design, in compile order
  - design/csr_pkg.sv
  - design/csr_req_if.sv
  - design/csr_rsp_if.sv
  - design/csr_cmd_stage.sv
  - design/mtimer_apb.sv
  - design/csr_file.sv
  - design/csr_retire_stage.sv
  - design/csr_unit_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/csr_unit_asserts.sv
      - testbench/csr_unit_tb.sv
